// ==== led_macros.svh ====
`ifndef LED_MACROS_SVH
`define LED_MACROS_SVH

// Pattern and strand size
`define LED_NUM_LEDS        6   // Pixels the moving pattern walks over
`define LED_STRAND_LEDS     8   // Pixels sent per frame
`define LED_FRAMES_PER_LED  3
`define LED_IDX_WIDTH       3

// Width of the shared event counter, wide enough for the reset gap
`define LED_CNT_WIDTH       6

// Pulse timing in clock cycles
`define LED_BIT_CYCLES      10
`define LED_T0H_CYCLES      3
`define LED_T1H_CYCLES      7
`define LED_RESET_CYCLES    40

// Colour word layout and the lit colour
`define LED_CHAN_WIDTH      8
`define LED_WORD_WIDTH      (3 * `LED_CHAN_WIDTH)
`define LED_GREEN_VAL       8'hA5
`define LED_RED_VAL         8'h3C
`define LED_BLUE_VAL        8'h81

`endif

// ==== led_pkg.sv ====
`default_nettype none

`include "led_macros.svh"

package led_pkg;

    // Pixel index asked for by the driver
    typedef struct packed {
        logic [`LED_IDX_WIDTH-1:0] idx;
    } led_req_t;

    // Channels in the order they go out on the wire
    typedef struct packed {
        logic [`LED_CHAN_WIDTH-1:0] green;
        logic [`LED_CHAN_WIDTH-1:0] red;
        logic [`LED_CHAN_WIDTH-1:0] blue;
    } rgb_t;

    // Shift word for the driver, channel view for the generator
    typedef union packed {
        logic [`LED_WORD_WIDTH-1:0] word;
        rgb_t                       rgb;
    } pixel_color_t;

endpackage

`default_nettype wire

// ==== evt_counter.sv ====
`default_nettype none

`include "led_macros.svh"

module evt_counter (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      evt_in,
    input  logic [`LED_CNT_WIDTH-1:0] limit,
    output logic [`LED_CNT_WIDTH-1:0] count,
    output logic                      wrap
);

    logic [`LED_CNT_WIDTH-1:0] last_count;

    assign last_count = limit - `LED_CNT_WIDTH'(1);

    // High on the event that takes count back to zero
    assign wrap = evt_in && (count == last_count);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else if (evt_in) begin
            count <= count + `LED_CNT_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

// ==== moving_pix.sv ====
`default_nettype none

`include "led_macros.svh"

module moving_pix (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  req_valid,
    input  led_pkg::led_req_t     req,
    output logic                  req_ready,
    output logic                  color_valid,
    output led_pkg::pixel_color_t color
);

    logic                      req_xfer;
    logic                      frame_end;
    logic                      frame_wrap;
    logic [`LED_IDX_WIDTH-1:0] lit_idx;
    led_pkg::pixel_color_t     lit_color;
    led_pkg::pixel_color_t     black;

    assign req_xfer = req_valid && req_ready;

    // Request for the last strand pixel closes the frame
    assign frame_end = req_xfer &&
                       (req.idx == `LED_IDX_WIDTH'(`LED_STRAND_LEDS - 1));

    // Lit colour is built channel by channel
    always_comb begin
        lit_color.rgb.green = `LED_GREEN_VAL;
        lit_color.rgb.red   = `LED_RED_VAL;
        lit_color.rgb.blue  = `LED_BLUE_VAL;
        black.word          = '0;
    end

    // Frames shown so far for the current lit pixel
    evt_counter u_frame_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt_in (frame_end),
        .limit  (`LED_CNT_WIDTH'(`LED_FRAMES_PER_LED)),
        .count  (),
        .wrap   (frame_wrap)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            lit_idx <= '0;
        end else if (frame_wrap) begin
            if (lit_idx == `LED_IDX_WIDTH'(`LED_NUM_LEDS - 1)) begin
                lit_idx <= '0;
            end else begin
                lit_idx <= lit_idx + `LED_IDX_WIDTH'(1);
            end
        end
    end

    // One request in flight, ready drops until the answer is out
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            req_ready   <= 1'b1;
            color_valid <= 1'b0;
        end else begin
            color_valid <= req_xfer;
            req_ready   <= !req_xfer;
        end
    end

    // Uses the lit index from before any advance on this edge
    always_ff @(posedge clk_in) begin
        if (req_xfer) begin
            color <= (req.idx == lit_idx) ? lit_color : black;
        end
    end

endmodule

`default_nettype wire

// ==== strand_driver.sv ====
`default_nettype none

`include "led_macros.svh"

module strand_driver (
    input  logic                  clk_in,
    input  logic                  rst_in,
    output logic                  req_valid,
    output led_pkg::led_req_t     req,
    input  logic                  req_ready,
    input  logic                  color_valid,
    input  led_pkg::pixel_color_t color,
    output logic                  data_out
);

    typedef enum logic [1:0] {
        GAP,
        REQUEST,
        WAIT,
        SEND
    } drv_state_t;

    drv_state_t state;
    drv_state_t state_next;

    led_pkg::pixel_color_t shift_word;

    logic [`LED_CNT_WIDTH-1:0] cyc_limit;
    logic [`LED_CNT_WIDTH-1:0] cyc_count;
    logic                      cyc_evt;
    logic                      cyc_wrap;
    logic                      bit_evt;
    logic                      bit_wrap;
    logic [`LED_CNT_WIDTH-1:0] pix_count;
    logic                      pix_wrap;
    logic [`LED_CNT_WIDTH-1:0] high_time;
    logic                      cur_bit;
    logic                      line_next;

    // The cycle counter times both the reset gap and each bit
    assign cyc_evt   = (state == GAP) || (state == SEND);
    assign cyc_limit = (state == GAP) ? `LED_CNT_WIDTH'(`LED_RESET_CYCLES)
                                      : `LED_CNT_WIDTH'(`LED_BIT_CYCLES);

    assign bit_evt = cyc_wrap && (state == SEND);   // End of a bit

    evt_counter u_cyc_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt_in (cyc_evt),
        .limit  (cyc_limit),
        .count  (cyc_count),
        .wrap   (cyc_wrap)
    );

    evt_counter u_bit_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt_in (bit_evt),
        .limit  (`LED_CNT_WIDTH'(`LED_WORD_WIDTH)),
        .count  (),
        .wrap   (bit_wrap)
    );

    evt_counter u_pix_cnt (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .evt_in (bit_wrap),                        // Last bit of a pixel
        .limit  (`LED_CNT_WIDTH'(`LED_STRAND_LEDS)),
        .count  (pix_count),
        .wrap   (pix_wrap)
    );

    // Request side
    assign req_valid = (state == REQUEST);
    assign req.idx   = pix_count[`LED_IDX_WIDTH-1:0];  // Stable until the pixel is sent

    always_comb begin
        state_next = state;
        case (state)
            GAP: begin
                if (cyc_wrap) begin
                    state_next = REQUEST;
                end
            end
            REQUEST: begin
                if (req_valid && req_ready) begin
                    state_next = WAIT;
                end
            end
            WAIT: begin
                if (color_valid) begin
                    state_next = SEND;
                end
            end
            SEND: begin
                if (pix_wrap) begin
                    state_next = GAP;      // Frame done, hold the line low
                end else if (bit_wrap) begin
                    state_next = REQUEST;  // Fetch the next pixel
                end
            end
            default: begin
                state_next = GAP;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= GAP;
        end else begin
            state <= state_next;
        end
    end

    // MSB goes out first
    always_ff @(posedge clk_in) begin
        if ((state == WAIT) && color_valid) begin
            shift_word <= color;
        end else if (bit_evt) begin
            shift_word.word <= {shift_word.word[`LED_WORD_WIDTH-2:0], 1'b0};
        end
    end

    assign cur_bit   = shift_word.word[`LED_WORD_WIDTH-1];
    assign high_time = cur_bit ? `LED_CNT_WIDTH'(`LED_T1H_CYCLES)
                               : `LED_CNT_WIDTH'(`LED_T0H_CYCLES);

    // High for the first part of the bit, low for the rest
    assign line_next = (state == SEND) && (cyc_count < high_time);

    // Registered so the line has no glitches
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            data_out <= 1'b0;
        end else begin
            data_out <= line_next;
        end
    end

endmodule

`default_nettype wire

// ==== led_strand_top.sv ====
`default_nettype none

module led_strand_top (
    input  logic clk_in,
    input  logic rst_in,
    output logic data_out
);

    // Request channel, driver to generator
    logic                  req_valid;
    led_pkg::led_req_t     req;
    logic                  req_ready;

    // Response channel, generator to driver
    logic                  color_valid;
    led_pkg::pixel_color_t color;

    moving_pix u_pattern (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .color_valid (color_valid),
        .color       (color)
    );

    strand_driver u_driver (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .color_valid (color_valid),
        .color       (color),
        .data_out    (data_out)         // Straight to the strand
    );

endmodule

`default_nettype wire

// ==== tb_led_strand.sv ====
`default_nettype none

`include "led_macros.svh"

module tb_led_strand;

    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DELAY   = 10;  // After the rising edge
    localparam int RESET_CYCLES  = 16;
    localparam int TOTAL_FRAMES  = 2 * `LED_FRAMES_PER_LED * `LED_NUM_LEDS + 2;

    // Gap, then per pixel one request cycle, one response cycle and 24 bits
    localparam int FRAME_CYCLES  = `LED_RESET_CYCLES +
        `LED_STRAND_LEDS * (2 + `LED_WORD_WIDTH * `LED_BIT_CYCLES);
    localparam int WATCHDOG_CYCLES = (TOTAL_FRAMES * FRAME_CYCLES + RESET_CYCLES) * 2;

    // One decoded pixel word and where it sits in the run
    typedef struct packed {
        int                    frame;
        int                    idx;
        led_pkg::pixel_color_t color;
    } rx_pixel_t;

    logic clk_in;
    logic rst_in;
    logic data_out;

    // Decoder state
    logic                        line_prev;
    logic                        seen_pulse;
    logic                        bit_val;
    logic [`LED_WORD_WIDTH-1:0]  shift_acc;
    int                          cyc_now;
    int                          high_len;
    int                          low_len;
    int                          last_rise;
    int                          bit_cnt;
    int                          pix_cnt;
    int                          frame_num;
    int                          frames_done;
    rx_pixel_t                   rx_item;

    // Compare side
    rx_pixel_t                   rx_q[$];
    rx_pixel_t                   cmp_item;

    led_strand_top u_dut (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .data_out (data_out)
    );

    initial clk_in = 1'b0;

    always #CLK_HALF clk_in = ~clk_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Colour the strand should show for one pixel of one frame
    function automatic led_pkg::pixel_color_t expected_color(input int frame, input int idx);
        led_pkg::pixel_color_t c;
        int                    lit;
        lit    = (frame / `LED_FRAMES_PER_LED) % `LED_NUM_LEDS;
        c.word = '0;
        if (idx == lit) begin               // Indices past the pattern never match
            c.rgb.green = `LED_GREEN_VAL;
            c.rgb.red   = `LED_RED_VAL;
            c.rgb.blue  = `LED_BLUE_VAL;
        end
        return c;
    endfunction

    task automatic check_color(input led_pkg::pixel_color_t got,
                               input led_pkg::pixel_color_t exp,
                               input int frame,
                               input int idx);
        if (got !== exp) begin
            $display("Mismatch data_out pixel word frame %0d index %0d:", frame, idx);
            $display("  got      green 0x%h red 0x%h blue 0x%h",
                     got.rgb.green, got.rgb.red, got.rgb.blue);
            $display("  expected green 0x%h red 0x%h blue 0x%h",
                     exp.rgb.green, exp.rgb.red, exp.rgb.blue);
            abort_run("pixel word differs from the expected colour");
        end
    endtask

    // A pulse must be one of the two legal high times
    task automatic compare_pulse_width(input int got);
        if ((got != `LED_T0H_CYCLES) && (got != `LED_T1H_CYCLES)) begin
            $display("Mismatch data_out high time: got 0x%h, expected 0x%h or 0x%h",
                     got, `LED_T0H_CYCLES, `LED_T1H_CYCLES);
            abort_run("pulse high time is neither a 0 bit nor a 1 bit");
        end
    endtask

    task automatic verify_bit_spacing(input int got);
        if (got != `LED_BIT_CYCLES) begin
            $display("Mismatch data_out bit period: got 0x%h, expected 0x%h",
                     got, `LED_BIT_CYCLES);
            abort_run("bits within a pixel are not evenly spaced");
        end
    endtask

    task automatic frame_size_check(input int got, input int frame);
        if (got != `LED_STRAND_LEDS) begin
            $display("Mismatch data_out pixels in frame %0d: got 0x%h, expected 0x%h",
                     frame, got, `LED_STRAND_LEDS);
            abort_run("frame does not hold one word per strand pixel");
        end
    endtask

    // Line decoder, samples on the falling edge where data_out is settled
    always @(negedge clk_in) begin
        if (rst_in) begin
            if (data_out !== 1'b0) begin
                abort_run("data_out is not low during reset");
            end
            line_prev   = 1'b0;
            seen_pulse  = 1'b0;
            shift_acc   = '0;
            cyc_now     = 0;
            high_len    = 0;
            low_len     = 0;
            last_rise   = 0;
            bit_cnt     = 0;
            pix_cnt     = 0;
            frame_num   = 0;
            frames_done = 0;
        end else begin
            if ($isunknown(data_out)) begin
                abort_run("data_out is unknown after reset");
            end
            cyc_now = cyc_now + 1;
            if (data_out) begin
                if (!line_prev) begin
                    // First pulse must follow a full gap after reset
                    if (!seen_pulse && (low_len < `LED_RESET_CYCLES)) begin
                        abort_run("data_out went high too soon after reset");
                    end
                    seen_pulse = 1'b1;
                    if (bit_cnt != 0) begin
                        verify_bit_spacing(cyc_now - last_rise);
                    end
                    last_rise = cyc_now;
                    high_len  = 0;
                end
                high_len = high_len + 1;
            end else begin
                if (line_prev) begin
                    compare_pulse_width(high_len);
                    bit_val   = (high_len == `LED_T1H_CYCLES);
                    shift_acc = {shift_acc[`LED_WORD_WIDTH-2:0], bit_val};   // MSB first
                    bit_cnt   = bit_cnt + 1;
                    if (bit_cnt == `LED_WORD_WIDTH) begin
                        rx_item.frame      = frame_num;
                        rx_item.idx        = pix_cnt;
                        rx_item.color.word = shift_acc;
                        rx_q.push_back(rx_item);
                        pix_cnt = pix_cnt + 1;
                        bit_cnt = 0;
                    end
                    low_len = 0;
                end
                low_len = low_len + 1;
                // A long low run closes the frame
                if ((low_len == `LED_RESET_CYCLES) && ((pix_cnt > 0) || (bit_cnt > 0))) begin
                    if (bit_cnt != 0) begin
                        abort_run("frame ended in the middle of a pixel word");
                    end
                    frame_size_check(pix_cnt, frame_num);
                    pix_cnt     = 0;
                    frame_num   = frame_num + 1;
                    frames_done = frames_done + 1;
                end
            end
            line_prev = data_out;
        end
    end

    // Compares each decoded word with the reference
    always @(posedge clk_in) begin
        while (rx_q.size() > 0) begin
            cmp_item = rx_q.pop_front();
            check_color(cmp_item.color,
                        expected_color(cmp_item.frame, cmp_item.idx),
                        cmp_item.frame,
                        cmp_item.idx);
        end
    end

    initial begin
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b0;

        while (frames_done < TOTAL_FRAMES) begin
            @(posedge clk_in);
        end
        repeat (2) @(posedge clk_in);   // Let the last words drain

        $display("test passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        abort_run("run took too long, frames stopped arriving on data_out");
    end

endmodule

`default_nettype wire

// ==== led_strand.f ====
+incdir+.
led_pkg.sv
evt_counter.sv
moving_pix.sv
strand_driver.sv
led_strand_top.sv
tb_led_strand.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the LED strand testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_led_strand \
    --Mdir obj_dir \
    -f led_strand.f

# Output goes to the terminal, the search decides pass or fail
if ./obj_dir/Vtb_led_strand 2>&1 | tee /dev/stderr | grep -x "test passed" > /dev/null; then
    echo "Simulation finished without errors"
else
    echo "Simulation reported a failure"
    exit 1
fi
